// ==== logic/commitStage.sv ====
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module commitStage (
    input  logic                clk,
    input  logic                nrst,
    input  rvPipePkg::executedT d5,
    output logic                regWe,
    output logic [4:0]          regAddr,
    output logic [31:0]         regData,
    output rvPipePkg::commitT   commit,
    output logic                redirectValid,
    output logic [31:0]         redirectPc
);
    import rvPipePkg::*;

    executedT d6;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            d6        <= '0;
            d6.linkPc <= `RV_RESET_PC;
        end
        else
            d6 <= d5;
    end

    // jumps write the return address, everything else the alu result
    assign regData = (d6.pcSel == pcJal || d6.pcSel == pcJalr) ? d6.linkPc : d6.result;
    assign regAddr = d6.rd;
    assign regWe   = d6.valid && d6.we && d6.rd != 5'd0;

    assign commit.valid = d6.valid;
    assign commit.rd    = d6.rd;                      // zero for non-writers
    assign commit.data  = d6.we ? regData : 32'd0;
    assign commit.pc    = d6.linkPc - 32'd4;          // back to the instruction's own pc

    assign redirectValid = d6.taken;                  // execute only marks valid records
    assign redirectPc    = d6.target;

    redirectRetires: assert property (@(posedge clk) disable iff (!nrst)
        redirectValid |-> commit.valid);

endmodule

// ==== logic/decodeStage.sv ====
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module decodeStage (
    input  logic                clk,
    input  logic                nrst,
    input  logic                instrValid,
    output logic                instrReady,
    input  logic [31:0]         instr,
    input  logic [31:0]         instrPc,
    input  rvPipePkg::issuedT   d4,        // stage 4 record, for hazard check
    input  rvPipePkg::executedT d5,        // stage 5 record, for hazard check
    output rvPipePkg::decodedT  d3
);
    import rvPipePkg::*;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] immI, immB, immJ;
    logic        shiftOk;    // funct7 legal for a shift or add/sub
    logic        readyEn;    // set one edge after reset release
    logic        stall;
    decodedT     dec;        // decoded form of the incoming word

    // funct3 to alu op, alt is funct7[5] where it means sub or sra
    function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? aluSub : aluAdd;
            3'b001:  return aluSll;
            3'b010:  return aluSlt;
            3'b011:  return aluSltu;
            3'b100:  return aluXor;
            3'b101:  return alt ? aluSra : aluSrl;
            3'b110:  return aluOr;
            default: return aluAnd;
        endcase
    endfunction

    // a source matches a writer still in flight in issue or execute
    function automatic logic inFlight(input logic [4:0] src, input issuedT s4,
                                      input executedT s5);
        return (src != 5'd0) &&
               ((s4.valid && s4.we && s4.rd == src) || (s5.valid && s5.we && s5.rd == src));
    endfunction

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign immI = {{20{instr[31]}}, instr[31:20]};
    assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign immJ = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign shiftOk = (funct7 == 7'b0000000) ||
                     (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3[1:0] == 2'b01));

    always_comb
    begin
        dec       = '0;          // unsupported words leave we low and no sources
        dec.valid = 1'b1;
        dec.pc    = instrPc;
        dec.shamt = instr[24:20];
        dec.aluOp = aluAdd;
        dec.bSel  = bSelReg;
        dec.pcSel = pcNone;
        case (opcode)
            `RV_OP_OP:
            begin
                // add/sub and srl/sra are the only ones taking 0100000
                if (funct7 == 7'b0000000 || (shiftOk && funct3 != 3'b001))
                begin
                    dec.we    = 1'b1;
                    dec.rd    = instr[11:7];
                    dec.rs1   = instr[19:15];
                    dec.rs2   = instr[24:20];
                    dec.aluOp = aluFromFunct(funct3, funct7[5]);
                end
            end
            `RV_OP_OPIMM:
            begin
                if (funct3[1:0] != 2'b01 || (shiftOk && !(funct3 == 3'b001 && funct7[5])))
                begin
                    dec.we    = 1'b1;
                    dec.rd    = instr[11:7];
                    dec.rs1   = instr[19:15];
                    dec.imm   = immI;
                    dec.aluOp = aluFromFunct(funct3, funct7[5] && funct3 == 3'b101);
                    dec.bSel  = (funct3[1:0] == 2'b01) ? bSelShamt : bSelImm;
                end
            end
            `RV_OP_BRANCH:
            begin
                if (funct3[2:1] == 2'b00)  // beq, bne
                begin
                    dec.rs1   = instr[19:15];
                    dec.rs2   = instr[24:20];
                    dec.bneq  = funct3[0];
                    dec.imm   = immB;
                    dec.pcSel = pcBranch;
                end
            end
            `RV_OP_JAL:
            begin
                dec.we    = 1'b1;
                dec.rd    = instr[11:7];
                dec.imm   = immJ;
                dec.pcSel = pcJal;
            end
            `RV_OP_JALR:
            begin
                if (funct3 == 3'b000)
                begin
                    dec.we    = 1'b1;
                    dec.rd    = instr[11:7];
                    dec.rs1   = instr[19:15];
                    dec.imm   = immI;
                    dec.pcSel = pcJalr;
                end
            end
            default: ;
        endcase
    end

    // hold in decode until the producer reaches commit
    assign stall      = d3.valid && (inFlight(d3.rs1, d4, d5) || inFlight(d3.rs2, d4, d5));
    assign instrReady = readyEn && !stall;

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            readyEn <= 1'b0;
            d3      <= '0;
            d3.pc   <= `RV_RESET_PC;
        end
        else
        begin
            readyEn <= 1'b1;
            if (!stall)
            begin
                if (instrValid && instrReady)
                    d3 <= dec;
                else
                    d3.valid <= 1'b0;   // nothing accepted, stage goes empty
            end
        end
    end

    // a stalled record must reach issue unchanged
    stallHold: assert property (@(posedge clk) disable iff (!nrst) stall |=> $stable(d3));

endmodule

// ==== logic/executeStage.sv ====
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module executeStage (
    input  logic                clk,
    input  logic                nrst,
    input  rvPipePkg::issuedT   d4,
    output rvPipePkg::executedT d5
);
    import rvPipePkg::*;

    logic [31:0] aluOut;
    logic [31:0] linkPc;
    logic [4:0]  shift;
    logic        taken;
    logic [31:0] target;

    assign shift  = d4.opB[4:0];   // only low five bits count for shifts
    assign linkPc = d4.pc + 32'd4;

    always_comb
    begin
        case (d4.aluOp)
            aluSub:  aluOut = d4.opA - d4.opB;
            aluAnd:  aluOut = d4.opA & d4.opB;
            aluOr:   aluOut = d4.opA | d4.opB;
            aluXor:  aluOut = d4.opA ^ d4.opB;
            aluSlt:  aluOut = {31'd0, $signed(d4.opA) < $signed(d4.opB)};
            aluSltu: aluOut = {31'd0, d4.opA < d4.opB};
            aluSll:  aluOut = d4.opA << shift;
            aluSrl:  aluOut = d4.opA >> shift;
            aluSra:  aluOut = $unsigned($signed(d4.opA) >>> shift);
            default: aluOut = d4.opA + d4.opB;
        endcase
    end

    // branch and jump resolution
    always_comb
    begin
        taken  = 1'b0;
        target = d4.pc + d4.imm;
        case (d4.pcSel)
            pcBranch: taken = (d4.opA == d4.rs2Val) != d4.bneq;
            pcJal:    taken = 1'b1;
            pcJalr:
            begin
                taken  = 1'b1;
                target = (d4.opA + d4.imm) & ~32'd1;   // lsb cleared
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            d5        <= '0;
            d5.linkPc <= `RV_RESET_PC;
        end
        else
        begin
            d5.valid  <= d4.valid;
            d5.we     <= d4.we;
            d5.rd     <= d4.rd;
            d5.result <= aluOut;
            d5.linkPc <= linkPc;
            d5.pcSel  <= d4.pcSel;
            d5.taken  <= d4.valid && taken;   // bubbles never redirect
            d5.target <= target;
        end
    end

    // only a control transfer can be taken
    takenKind: assert property (@(posedge clk) disable iff (!nrst)
        d5.taken |-> d5.valid && d5.pcSel != pcNone);

endmodule

// ==== logic/issueStage.sv ====
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module issueStage (
    input  logic               clk,
    input  logic               nrst,
    input  rvPipePkg::decodedT d3,
    input  logic               stall,   // decode is holding d3
    input  logic [31:0]        dataA,   // rs1 read data
    input  logic [31:0]        dataB,   // rs2 read data
    output rvPipePkg::issuedT  d4
);
    import rvPipePkg::*;

    logic [31:0] opBSel;

    // operand b source
    always_comb
    begin
        case (d3.bSel)
            bSelImm:   opBSel = d3.imm;
            bSelShamt: opBSel = {27'd0, d3.shamt};
            default:   opBSel = dataB;
        endcase
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            d4    <= '0;
            d4.pc <= `RV_RESET_PC;
        end
        else
        begin
            d4.valid  <= d3.valid && !stall;   // bubble while decode waits
            d4.we     <= d3.we;
            d4.bneq   <= d3.bneq;
            d4.rd     <= d3.rd;
            d4.aluOp  <= d3.aluOp;
            d4.pcSel  <= d3.pcSel;
            d4.opA    <= dataA;
            d4.opB    <= opBSel;
            d4.rs2Val <= dataB;                // raw rs2, branches compare this
            d4.imm    <= d3.imm;               // branch and jump offsets
            d4.pc     <= d3.pc;
        end
    end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module regFile (
    input  logic        clk,
    input  logic        nrst,
    input  logic        we,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData,
    input  logic [4:0]  srcA,
    input  logic [4:0]  srcB,
    output logic [31:0] dataA,
    output logic [31:0] dataB
);

    logic [31:0] regs [`RV_NREG];
    logic        hitA, hitB;   // read address matches this cycle's write

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < `RV_NREG; i++)
                regs[i] <= '0;
        end
        else if (we && writeAddr != 5'd0)   // x0 never stored
        begin
            regs[writeAddr] <= writeData;
        end
    end

    assign hitA = we && (writeAddr == srcA);
    assign hitB = we && (writeAddr == srcB);

    // x0 first, then bypass the pending write, then the array
    assign dataA = (srcA == 5'd0) ? 32'd0 :
                   hitA           ? writeData : regs[srcA];
    assign dataB = (srcB == 5'd0) ? 32'd0 :
                   hitB           ? writeData : regs[srcB];

endmodule

// ==== logic/rvPipePkg.sv ====
package rvPipePkg;

    // alu operation, picked from funct3 plus funct7[5]
    typedef enum logic [3:0]
    {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluSlt,
        aluSltu,
        aluSll,
        aluSrl,
        aluSra
    } aluOpT;

    // where operand b comes from in issue
    typedef enum logic [1:0]
    {
        bSelReg,    // rs2 read data
        bSelImm,    // sign extended immediate
        bSelShamt   // zero extended shift amount
    } bSelT;

    // control transfer kind, resolved in execute
    typedef enum logic [1:0]
    {
        pcNone,
        pcBranch,
        pcJal,
        pcJalr
    } pcSelT;

    // stage 3 record, decode to issue
    typedef struct packed
    {
        logic        valid;
        logic        we;      // writes rd
        logic        bneq;    // bne when set, beq otherwise
        logic [4:0]  rd;
        logic [4:0]  rs1;     // zero when not read
        logic [4:0]  rs2;     // zero when not read
        aluOpT       aluOp;
        bSelT        bSel;
        pcSelT       pcSel;
        logic [31:0] imm;     // i, b or j immediate
        logic [4:0]  shamt;
        logic [31:0] pc;
    } decodedT;

    // stage 4 record, issue to execute
    typedef struct packed
    {
        logic        valid;
        logic        we;
        logic        bneq;
        logic [4:0]  rd;
        aluOpT       aluOp;
        pcSelT       pcSel;
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] rs2Val;  // compared against opA for branches
        logic [31:0] imm;
        logic [31:0] pc;
    } issuedT;

    // stage 5 record, execute to commit
    typedef struct packed
    {
        logic        valid;
        logic        we;
        logic [4:0]  rd;
        logic [31:0] result;  // alu output
        logic [31:0] linkPc;  // pc + 4
        pcSelT       pcSel;
        logic        taken;
        logic [31:0] target;
    } executedT;

    // retired instruction as seen on the commit port
    typedef struct packed
    {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic [31:0] pc;
    } commitT;

endpackage

// ==== logic/rvPipeTop.sv ====
`timescale 1ns/1ps

module rvPipeTop (
    input  logic              clk,
    input  logic              nrst,
    input  logic              instrValid,
    output logic              instrReady,
    input  logic [31:0]       instr,
    input  logic [31:0]       instrPc,
    output rvPipePkg::commitT commit,
    output logic              redirectValid,
    output logic [31:0]       redirectPc
);
    import rvPipePkg::*;

    decodedT     d3;          // stage 3 register
    issuedT      d4;          // stage 4 register
    executedT    d5;          // stage 5 register
    logic        regWe;
    logic [4:0]  regAddr;
    logic [31:0] regData;
    logic [31:0] dataA, dataB;

    decodeStage decodeStage_inst (
        .clk        (clk),
        .nrst       (nrst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .instrPc    (instrPc),
        .d4         (d4),
        .d5         (d5),
        .d3         (d3)
    );

    // sources come straight from the stage 3 register
    regFile regFile_inst (
        .clk       (clk),
        .nrst      (nrst),
        .we        (regWe),
        .writeAddr (regAddr),
        .writeData (regData),
        .srcA      (d3.rs1),
        .srcB      (d3.rs2),
        .dataA     (dataA),
        .dataB     (dataB)
    );

    // ready low with a valid d3 means decode is stalled
    issueStage issueStage_inst (
        .clk   (clk),
        .nrst  (nrst),
        .d3    (d3),
        .stall (~instrReady),
        .dataA (dataA),
        .dataB (dataB),
        .d4    (d4)
    );

    executeStage executeStage_inst (
        .clk  (clk),
        .nrst (nrst),
        .d4   (d4),
        .d5   (d5)
    );

    commitStage commitStage_inst (
        .clk           (clk),
        .nrst          (nrst),
        .d5            (d5),
        .regWe         (regWe),
        .regAddr       (regAddr),
        .regData       (regData),
        .commit        (commit),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

endmodule

// ==== logic/rvPipe_macros.svh ====
`ifndef RV_PIPE_MACROS_SVH
`define RV_PIPE_MACROS_SVH

// architectural register count, x0 included
`define RV_NREG 32

// pc value held in every stage record after reset
`define RV_RESET_PC 32'h0000_0000

// opcode field values, instr[6:0]
`define RV_OP_OP     7'b0110011  // register-register alu
`define RV_OP_OPIMM  7'b0010011  // register-immediate alu and shifts
`define RV_OP_BRANCH 7'b1100011  // conditional branch, only beq/bne decoded
`define RV_OP_JAL    7'b1101111  // pc-relative jump and link
`define RV_OP_JALR   7'b1100111  // register jump and link

// the low two opcode bits are always 2'b11 for 32-bit words,
// anything else falls through decode as unsupported

`endif

// ==== rvPipe.f ====
+incdir+logic
+incdir+verif
logic/rvPipePkg.sv
logic/regFile.sv
logic/decodeStage.sv
logic/issueStage.sv
logic/executeStage.sv
logic/commitStage.sv
logic/rvPipeTop.sv
verif/rvPipeTb.sv

// ==== verif/rvPipeTbTable.svh ====
`ifndef RV_PIPE_TB_TABLE_SVH
`define RV_PIPE_TB_TABLE_SVH

// columns: word, commit expected, rd, data, redirect expected, target
// pc of each row is four times its index, registers start at zero

localparam int numEntries = 28;

stimEntryT tbl [numEntries];

function automatic void loadTable();
    // alu results from the isa definitions, x1 = 5 and x2 = -3 feed the rest
    tbl[0]  = makeRow(iType(12'd5, 5'd0, 3'd0, 5'd1), 1'b1, 5'd1, 32'h5, 1'b0, '0);
    tbl[1]  = makeRow(iType(12'hffd, 5'd0, 3'd0, 5'd2), 1'b1, 5'd2, 32'hfffffffd, 1'b0, '0);
    tbl[2]  = makeRow(rType(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b1, 5'd3, 32'h2, 1'b0, '0);
    tbl[3]  = makeRow(rType(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1'b1, 5'd4, 32'h8, 1'b0, '0);
    tbl[4]  = makeRow(rType(7'h00, 5'd1, 5'd2, 3'd2, 5'd5), 1'b1, 5'd5, 32'h1, 1'b0, '0);
    tbl[5]  = makeRow(rType(7'h00, 5'd1, 5'd2, 3'd3, 5'd6), 1'b1, 5'd6, 32'h0, 1'b0, '0);
    tbl[6]  = makeRow(iType(12'h0f0, 5'd2, 3'd4, 5'd7), 1'b1, 5'd7, 32'hffffff0d, 1'b0, '0);
    tbl[7]  = makeRow(iType(12'h401, 5'd2, 3'd5, 5'd8), 1'b1, 5'd8, 32'hfffffffe, 1'b0, '0);
    tbl[8]  = makeRow(iType(12'h01c, 5'd2, 3'd5, 5'd9), 1'b1, 5'd9, 32'hf, 1'b0, '0);
    tbl[9]  = makeRow(iType(12'h004, 5'd1, 3'd1, 5'd10), 1'b1, 5'd10, 32'h50, 1'b0, '0);
    tbl[10] = makeRow(rType(7'h00, 5'd10, 5'd7, 3'd6, 5'd11), 1'b1, 5'd11, 32'hffffff5d, 1'b0, '0);
    tbl[11] = makeRow(iType(12'h0ff, 5'd11, 3'd7, 5'd12), 1'b1, 5'd12, 32'h5d, 1'b0, '0);
    tbl[12] = makeRow(rType(7'h20, 5'd3, 5'd2, 3'd5, 5'd13), 1'b1, 5'd13, 32'hffffffff, 1'b0, '0);
    tbl[13] = makeRow(iType(12'hffe, 5'd2, 3'd2, 5'd14), 1'b1, 5'd14, 32'h1, 1'b0, '0);
    tbl[14] = makeRow(iType(12'hfff, 5'd1, 3'd3, 5'd15), 1'b1, 5'd15, 32'h1, 1'b0, '0);
    // write to x0 retires with its sum, then x0 is read back as zero
    tbl[15] = makeRow(iType(12'd7, 5'd1, 3'd0, 5'd0), 1'b1, 5'd0, 32'hc, 1'b0, '0);
    tbl[16] = makeRow(rType(7'h20, 5'd1, 5'd0, 3'd0, 5'd16), 1'b1, 5'd16, 32'hfffffffb, 1'b0, '0);
    // beq/bne, not taken and taken, target is pc + imm
    tbl[17] = makeRow(bType(13'd8, 5'd12, 5'd1, 3'd0), 1'b1, 5'd0, 32'h0, 1'b0, '0);
    tbl[18] = makeRow(bType(13'd12, 5'd1, 5'd1, 3'd0), 1'b1, 5'd0, 32'h0, 1'b1, 32'h54);
    tbl[19] = makeRow(bType(13'h1ff0, 5'd2, 5'd1, 3'd1), 1'b1, 5'd0, 32'h0, 1'b1, 32'h3c);
    tbl[20] = makeRow(bType(13'd8, 5'd4, 5'd4, 3'd1), 1'b1, 5'd0, 32'h0, 1'b0, '0);
    // jumps link pc + 4, jalr targets land odd and get bit 0 cleared
    tbl[21] = makeRow(jType(21'd20, 5'd17), 1'b1, 5'd17, 32'h58, 1'b1, 32'h68);
    tbl[22] = makeRow(jalrType(12'd6, 5'd1, 5'd18), 1'b1, 5'd18, 32'h5c, 1'b1, 32'ha);
    tbl[23] = makeRow(jalrType(12'd3, 5'd18, 5'd19), 1'b1, 5'd19, 32'h60, 1'b1, 32'h5e);
    // custom-0 opcode naming x1, then a mul encoding naming x3
    tbl[24] = makeRow(32'h0000008b, 1'b1, 5'd0, 32'h0, 1'b0, '0);
    tbl[25] = makeRow(rType(7'h01, 5'd1, 5'd1, 3'd0, 5'd3), 1'b1, 5'd0, 32'h0, 1'b0, '0);
    tbl[26] = makeRow(iType(12'd0, 5'd1, 3'd0, 5'd20), 1'b1, 5'd20, 32'h5, 1'b0, '0);
    tbl[27] = makeRow(rType(7'h00, 5'd0, 5'd3, 3'd0, 5'd21), 1'b1, 5'd21, 32'h2, 1'b0, '0);
endfunction

`endif

// ==== verif/rvPipeTb.sv ====
`timescale 1ns/1ps
`include "rvPipe_macros.svh"

module rvPipeTb;
    import rvPipePkg::*;

    // one table row, pc comes from the row index
    typedef struct packed
    {
        logic        [31:0] word;
        logic               expCommit;
        logic        [4:0]  rd;
        logic        [31:0] data;
        logic               expRedirect;
        logic        [31:0] target;
    } stimEntryT;

    logic        clk = 1'b0;
    logic        nrst;
    logic        instrValid;
    logic        instrReady;
    logic [31:0] instr;
    logic [31:0] instrPc;
    commitT      commit;
    logic        redirectValid;
    logic [31:0] redirectPc;

    integer      seed = 32'h5a62;
    int          valueErrors = 0;
    int          otherErrors = 0;
    int          nextIdx = 0;        // next row due to retire
    int          commitsSeen = 0;
    int          commitsWanted = 0;

    // instruction encoders, field order from the isa formats
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `RV_OP_OP};
    endfunction

    function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, `RV_OP_OPIMM};
    endfunction

    function automatic logic [31:0] jalrType(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, `RV_OP_JALR};
    endfunction

    // b format scatters the offset, bit 0 is implied zero
    function automatic logic [31:0] bType(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OP_BRANCH};
    endfunction

    function automatic logic [31:0] jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OP_JAL};
    endfunction

    function automatic stimEntryT makeRow(input logic [31:0] word, input logic expCommit,
                                          input logic [4:0] rd, input logic [31:0] data,
                                          input logic expRedirect, input logic [31:0] target);
        stimEntryT r;
        r.word        = word;
        r.expCommit   = expCommit;
        r.rd          = rd;
        r.data        = data;
        r.expRedirect = expRedirect;
        r.target      = target;
        return r;
    endfunction

    `include "rvPipeTbTable.svh"

    rvPipeTop rvPipeTop_inst (
        .clk           (clk),
        .nrst          (nrst),
        .instrValid    (instrValid),
        .instrReady    (instrReady),
        .instr         (instr),
        .instrPc       (instrPc),
        .commit        (commit),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc)
    );

    always #4 clk = ~clk;   // 8 ns period

    task automatic reportMismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
        $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, name, got, want);
        valueErrors++;
    endtask

    // hold one word on the input until a ready edge takes it
    task automatic sendWord(input int idx);
        logic accepted;
        instrValid <= 1'b1;
        instr      <= tbl[idx].word;
        instrPc    <= idx * 4;
        accepted = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = instrReady;   // stable through the low half
            @(posedge clk);
        end
    endtask

    // compare one retiring instruction against the next row in order
    task automatic checkCommit();
        stimEntryT want;
        while (nextIdx < numEntries && !tbl[nextIdx].expCommit)
            nextIdx++;
        if (nextIdx >= numEntries)
        begin
            $display("commit at %0t ns with pc %h after the last table row", $time, commit.pc);
            otherErrors++;
        end
        else
        begin
            want = tbl[nextIdx];
            if (commit.pc !== nextIdx * 4)
                reportMismatch("commit.pc", commit.pc, nextIdx * 4);
            if (commit.rd !== want.rd)
                reportMismatch("commit.rd", {27'd0, commit.rd}, {27'd0, want.rd});
            if (commit.data !== want.data)
                reportMismatch("commit.data", commit.data, want.data);
            if (redirectValid !== want.expRedirect)
                reportMismatch("redirectValid", {31'd0, redirectValid}, {31'd0, want.expRedirect});
            if (want.expRedirect && redirectPc !== want.target)
                reportMismatch("redirectPc", redirectPc, want.target);
            nextIdx++;
            commitsSeen++;
        end
    endtask

    // outputs sampled mid cycle, away from the rising edge
    always @(negedge clk)
    begin
        if (nrst === 1'b1)
        begin
            if (commit.valid)
                checkCommit();
            else if (redirectValid)
            begin
                $display("redirect at %0t ns with no instruction retiring", $time);
                otherErrors++;
            end
        end
    end

    initial
    begin
        int gap;
        nrst       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        instrPc    = '0;
        loadTable();
        for (int i = 0; i < numEntries; i++)
            if (tbl[i].expCommit)
                commitsWanted++;
        repeat (7) @(posedge clk);
        @(negedge clk);
        // pipeline must be quiet while held in reset
        if (instrReady !== 1'b0)
            reportMismatch("instrReady", {31'd0, instrReady}, 32'd0);
        if (commit.valid !== 1'b0)
            reportMismatch("commit.valid", {31'd0, commit.valid}, 32'd0);
        if (redirectValid !== 1'b0)
            reportMismatch("redirectValid", {31'd0, redirectValid}, 32'd0);
        @(posedge clk);
        nrst <= 1'b1;   // released after 8 edges
        for (int i = 0; i < numEntries; i++)
        begin
            sendWord(i);
            gap = $unsigned($random(seed)) % 3;   // 0..2 idle cycles
            if (gap > 0)
            begin
                instrValid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        instrValid <= 1'b0;
        wait (commitsSeen == commitsWanted);
        repeat (10) @(posedge clk);   // room for a stray extra commit
        $display("run done: %0d commits, %0d value errors, %0d other errors",
                 commitsSeen, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

    // watchdog, ten cycles per row plus slack for reset and drain
    initial
    begin
        repeat (numEntries * 10 + 100) @(posedge clk);
        $display("timeout at %0t ns: only %0d of %0d instructions retired",
                 $time, commitsSeen, commitsWanted);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
